// ==== Makefile ====
SIM      := verilator
FLAGS    := --binary --timing --assert
TOP      := tb_ex_stage
FILELIST := list.f

OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)
LOG      := sim.log
SOURCES  := $(shell grep -v '^+' $(FILELIST)) $(wildcard include/*.svh)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	$(BIN) | tee $(LOG)
	@if grep -q "TESTS FAILED" $(LOG) || ! grep -q "TESTS PASSED" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== list.f ====
+incdir+include
src/ex_pkg.sv
src/ex_stage_reg.sv
src/ex_operand_unit.sv
src/ex_alu.sv
src/ex_branch_unit.sv
src/ex_stage.sv
verif/tb_clock_gen.sv
verif/tb_ex_stage.sv

// ==== src/ex_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module ex_alu (
    input  ex_pkg::alu_op_e alu_op,
    input  logic            word_op,
    input  ex_pkg::xlen_t   op_a,
    input  ex_pkg::xlen_t   op_b,
    output ex_pkg::xlen_t   result
);
    import ex_pkg::*;

    logic [5:0] shamt;
    xlen_t      shift_src;
    xlen_t      raw;

    // word ops only look at 5 bits of shift amount
    assign shamt = word_op ? {1'b0, op_b[4:0]} : op_b[5:0];

    // right shifts on words start from the low half
    always_comb begin
        if (!word_op) begin
            shift_src = op_a;
        end else if (alu_op == sra) begin
            shift_src = {{(xlen - 32){op_a[31]}}, op_a[31:0]};
        end else begin
            shift_src = {{(xlen - 32){1'b0}}, op_a[31:0]};
        end
    end

    always_comb begin
        case (alu_op)
            add:    raw = op_a + op_b;
            sub:    raw = op_a - op_b;
            slt:    raw = xlen_t'($signed(op_a) < $signed(op_b));
            sltu:   raw = xlen_t'(op_a < op_b);
            xor_op: raw = op_a ^ op_b;
            or_op:  raw = op_a | op_b;
            and_op: raw = op_a & op_b;
            // sllw only keeps bits 31:0, upper half is dropped below
            sll:    raw = op_a << shamt;
            srl:    raw = shift_src >> shamt;
            sra:    raw = $signed(shift_src) >>> shamt;
            default: raw = '0;
        endcase
    end

    // addw, subw and the word shifts
    // sign-extend from bit 31
    assign result = word_op ? {{(xlen - 32){raw[31]}}, raw[31:0]} : raw;

endmodule

`default_nettype wire

// ==== src/ex_branch_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module ex_branch_unit (
    input  logic              item_valid,
    input  logic              handoff,
    input  ex_pkg::id_ex_t    item,
    input  ex_pkg::operands_t operands,
    output logic              pc_update,
    output ex_pkg::xlen_t     dnpc
);
    import ex_pkg::*;

    logic  cond_met;
    logic  is_jump;
    logic  is_branch;
    logic  predicted;
    xlen_t target;
    xlen_t seq_pc;

    // compare on forwarded values
    always_comb begin
        case (item.branch_cond)
            beq:     cond_met = operands.rs1_val == operands.rs2_val;
            bne:     cond_met = operands.rs1_val != operands.rs2_val;
            blt:     cond_met = $signed(operands.rs1_val) < $signed(operands.rs2_val);
            bge:     cond_met = $signed(operands.rs1_val) >= $signed(operands.rs2_val);
            bltu:    cond_met = operands.rs1_val < operands.rs2_val;
            bgeu:    cond_met = operands.rs1_val >= operands.rs2_val;
            default: cond_met = 1'b0;
        endcase
    end

    assign is_jump   = (item.op_class == jal) || (item.op_class == jalr);
    assign is_branch = item.op_class == branch;
    // decode guessed backward taken, forward not taken
    assign predicted = item.imm[xlen-1];

    // jalr is register relative, everything else pc relative
    assign target = ((item.op_class == jalr) ? operands.rs1_val : item.pc) + item.imm;
    assign seq_pc = item.pc + xlen_t'(inst_bytes);
    assign dnpc   = (is_jump || (is_branch && cond_met)) ? target : seq_pc;

    // fetch only hears about it when the item really leaves
    assign pc_update = handoff && (is_jump || (is_branch && (cond_met != predicted)));

    always_comb begin
        a_update_needs_item: assert (!pc_update || item_valid);
    end

endmodule

`default_nettype wire

// ==== src/ex_operand_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module ex_operand_unit (
    input  ex_pkg::id_ex_t    item,
    input  ex_pkg::fwd_t      mem_fwd,
    input  ex_pkg::fwd_t      wb_fwd,
    output ex_pkg::operands_t operands
);
    import ex_pkg::*;

    logic uses_rs2;

    // youngest writer wins, x0 is hardwired and never replaced
    function automatic xlen_t resolve(
        input reg_addr_t src,
        input xlen_t     decoded,
        input logic      enable,
        input fwd_t      mem_f,
        input fwd_t      wb_f
    );
        xlen_t val;
        val = decoded;
        if (enable && src != '0) begin
            if (mem_f.write && mem_f.rd == src) begin
                val = mem_f.data;
            end else if (wb_f.write && wb_f.rd == src) begin
                val = wb_f.data;
            end
        end
        return val;
    endfunction

    always_comb begin
        // only register ops and branches read rs2
        uses_rs2 = (item.op_class == alu_reg) || (item.op_class == branch);

        operands.rs1_val = resolve(item.rs1, item.src1, 1'b1, mem_fwd, wb_fwd);
        operands.rs2_val = resolve(item.rs2, item.src2, uses_rs2, mem_fwd, wb_fwd);

        // operand a
        case (item.op_class)
            lui:              operands.op_a = '0;
            auipc, jal, jalr: operands.op_a = item.pc;
            default:          operands.op_a = operands.rs1_val;
        endcase

        // operand b, jumps add the link offset
        case (item.op_class)
            alu_imm, lui, auipc: operands.op_b = item.imm;
            jal, jalr:           operands.op_b = xlen_t'(inst_bytes);
            default:             operands.op_b = operands.rs2_val;
        endcase

        // x0 and an unread rs2 keep what decode read
        a_no_x0_fwd: assert ((item.rs1 != '0 || operands.rs1_val == item.src1) &&
                             ((item.rs2 != '0 && uses_rs2) ||
                              operands.rs2_val == item.src2));
    end

endmodule

`default_nettype wire

// ==== src/ex_pkg.sv ====
`default_nettype none

package ex_pkg;

    // data path width
    localparam int xlen = 64;
    // fixed 32-bit encoding, no compressed ops
    localparam int inst_bytes = 4;

    typedef logic [xlen-1:0] xlen_t;
    typedef logic [4:0]      reg_addr_t;

    // instruction class from decode
    typedef enum logic [2:0] {
        alu_reg,
        alu_imm,
        lui,
        auipc,
        jal,
        jalr,
        branch
    } op_class_e;

    typedef enum logic [3:0] {
        add,
        sub,
        slt,
        sltu,
        xor_op,
        or_op,
        and_op,
        sll,
        srl,
        sra
    } alu_op_e;

    // encoded as funct3 so decode passes the field straight through
    typedef enum logic [2:0] {
        beq  = 3'b000,
        bne  = 3'b001,
        blt  = 3'b100,
        bge  = 3'b101,
        bltu = 3'b110,
        bgeu = 3'b111
    } branch_cond_e;

    // item from decode, rd is zero for branches
    typedef struct packed {
        xlen_t        pc;
        op_class_e    op_class;
        alu_op_e      alu_op;
        logic         word_op;
        branch_cond_e branch_cond;
        reg_addr_t    rd;
        reg_addr_t    rs1;
        reg_addr_t    rs2;
        xlen_t        src1;
        xlen_t        src2;
        // sign-extended by decode
        xlen_t        imm;
    } id_ex_t;

    // writeback seen from a later stage
    typedef struct packed {
        logic      write;
        reg_addr_t rd;
        xlen_t     data;
    } fwd_t;

    typedef struct packed {
        xlen_t     pc;
        reg_addr_t rd;
        xlen_t     result;
    } ex_mem_t;

    typedef struct packed {
        xlen_t rs1_val;
        xlen_t rs2_val;
        xlen_t op_a;
        xlen_t op_b;
    } operands_t;

endpackage

`default_nettype wire

// ==== src/ex_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module ex_stage (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            in_valid,
    output logic            in_ready,
    input  ex_pkg::id_ex_t  in_bus,
    output logic            out_valid,
    input  logic            out_ready,
    output ex_pkg::ex_mem_t out_bus,
    input  ex_pkg::fwd_t    mem_fwd,
    input  ex_pkg::fwd_t    wb_fwd,
    input  logic            branch_flush,
    output logic            pc_update,
    output ex_pkg::xlen_t   dnpc
);
    import ex_pkg::*;

    logic      item_valid;
    id_ex_t    item;
    operands_t operands;
    xlen_t     alu_result;
    logic      handoff;

    // single-cycle stage, MEM ready propagates straight back
    assign in_ready  = out_ready;
    assign out_valid = item_valid;
    assign handoff   = item_valid && out_ready;

    ex_stage_reg i_stage_reg (
        .clk        (clk),
        .rst_n      (rst_n),
        .flush      (branch_flush),
        .in_valid   (in_valid),
        .in_bus     (in_bus),
        .advance    (out_ready),
        .item_valid (item_valid),
        .item       (item)
    );

    ex_operand_unit i_operand_unit (
        .item     (item),
        .mem_fwd  (mem_fwd),
        .wb_fwd   (wb_fwd),
        .operands (operands)
    );

    ex_alu i_alu (
        .alu_op  (item.alu_op),
        .word_op (item.word_op),
        .op_a    (operands.op_a),
        .op_b    (operands.op_b),
        .result  (alu_result)
    );

    ex_branch_unit i_branch_unit (
        .item_valid (item_valid),
        .handoff    (handoff),
        .item       (item),
        .operands   (operands),
        .pc_update  (pc_update),
        .dnpc       (dnpc)
    );

    // jumps carry pc + 4 as their link value here
    assign out_bus = '{pc: item.pc, rd: item.rd, result: alu_result};

    // accepted and not flushed, so it shows up one cycle later
    a_one_cycle: assert property (
        @(posedge clk) disable iff (!rst_n)
        in_valid && in_ready && !branch_flush |=> out_valid
    );

    // stalled output stays put while forwarding sources are quiet
    a_hold_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        $past(out_valid && !out_ready) && $stable(mem_fwd) && $stable(wb_fwd)
            |-> $stable(out_bus)
    );

endmodule

`default_nettype wire

// ==== src/ex_stage_reg.sv ====
`timescale 1ns/1ps
`default_nettype none

module ex_stage_reg (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           flush,
    input  logic           in_valid,
    input  ex_pkg::id_ex_t in_bus,
    input  logic           advance,
    output logic           item_valid,
    output ex_pkg::id_ex_t item
);

    // valid bit, flush beats a load
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            item_valid <= 1'b0;
        end else if (flush) begin
            item_valid <= 1'b0;
        end else if (advance) begin
            item_valid <= in_valid;
        end
    end

    // payload only moves with advance
    // stale contents are masked by item_valid
    always_ff @(posedge clk) begin
        if (advance) begin
            item <= in_bus;
        end
    end

    // a flushed slot is empty on the next cycle, whatever advance did
    a_flush_empties: assert property (
        @(posedge clk) disable iff (!rst_n)
        flush |=> !item_valid
    );

endmodule

`default_nettype wire

// ==== verif/tb_clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic rst_n
);

    // 10 ns period
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // reset low for 10 cycles, released just after an edge
    initial begin
        rst_n = 1'b0;
        repeat (10) @(posedge clk);
        #1 rst_n = 1'b1;
    end

endmodule

`default_nettype wire

// ==== include/tb_ex_model.svh ====
`ifndef TB_EX_MODEL_SVH
`define TB_EX_MODEL_SVH

// register read with bypass, MEM beats WB, x0 always reads the decoded value
function automatic xlen_t bypassed_source(reg_addr_t r, xlen_t decoded, logic used,
                                          fwd_t m, fwd_t w);
    if (!used || r == 5'd0) return decoded;
    if (m.write && m.rd == r) return m.data;
    if (w.write && w.rd == r) return w.data;
    return decoded;
endfunction

function automatic xlen_t rs1_value(id_ex_t it, fwd_t m, fwd_t w);
    return bypassed_source(it.rs1, it.src1, 1'b1, m, w);
endfunction

// only register ops and branches read rs2
function automatic xlen_t rs2_value(id_ex_t it, fwd_t m, fwd_t w);
    return bypassed_source(it.rs2, it.src2, it.op_class inside {alu_reg, branch}, m, w);
endfunction

function automatic xlen_t alu_reference(alu_op_e op, logic word, xlen_t a, xlen_t b);
    xlen_t       full;
    logic [31:0] lo;
    case (op)
        add:     full = a + b;
        sub:     full = a - b;
        slt:     full = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
        sltu:    full = (a < b) ? 64'd1 : 64'd0;
        xor_op:  full = a ^ b;
        or_op:   full = a | b;
        and_op:  full = a & b;
        sll:     full = a << b[5:0];
        srl:     full = a >> b[5:0];
        sra:     full = $signed(a) >>> b[5:0];
        default: full = 64'd0;
    endcase
    if (!word) return full;
    // RV64 word forms, 32-bit shift then sign-extend
    case (op)
        sll:     lo = a[31:0] << b[4:0];
        srl:     lo = a[31:0] >> b[4:0];
        sra:     lo = $signed(a[31:0]) >>> b[4:0];
        default: lo = full[31:0];
    endcase
    return {{32{lo[31]}}, lo};
endfunction

function automatic xlen_t expected_result(id_ex_t it, fwd_t m, fwd_t w);
    xlen_t a;
    xlen_t b;
    case (it.op_class)
        lui:              a = 64'd0;
        auipc, jal, jalr: a = it.pc;
        default:          a = rs1_value(it, m, w);
    endcase
    // jumps produce the link address pc + 4
    case (it.op_class)
        alu_imm, lui, auipc: b = it.imm;
        jal, jalr:           b = 64'd4;
        default:             b = rs2_value(it, m, w);
    endcase
    return alu_reference(it.alu_op, it.word_op, a, b);
endfunction

function automatic logic branch_taken(id_ex_t it, fwd_t m, fwd_t w);
    xlen_t x;
    xlen_t y;
    x = rs1_value(it, m, w);
    y = rs2_value(it, m, w);
    case (it.branch_cond)
        beq:     return x == y;
        bne:     return x != y;
        blt:     return $signed(x) < $signed(y);
        bge:     return !($signed(x) < $signed(y));
        bltu:    return x < y;
        bgeu:    return !(x < y);
        default: return 1'b0;
    endcase
endfunction

// static guess is taken for a negative offset
function automatic logic needs_redirect(id_ex_t it, fwd_t m, fwd_t w);
    if (it.op_class == jal || it.op_class == jalr) return 1'b1;
    if (it.op_class != branch) return 1'b0;
    return branch_taken(it, m, w) != it.imm[63];
endfunction

function automatic xlen_t actual_next_pc(id_ex_t it, fwd_t m, fwd_t w);
    if (it.op_class == jalr) return rs1_value(it, m, w) + it.imm;
    if (it.op_class == jal) return it.pc + it.imm;
    if (it.op_class == branch && branch_taken(it, m, w)) return it.pc + it.imm;
    return it.pc + 64'd4;
endfunction

`endif

// ==== verif/tb_ex_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_ex_stage;
    import ex_pkg::*;

    `include "tb_ex_model.svh"

    // about 4 cycles per item at worst
    localparam int num_items  = 2000;
    localparam int max_cycles = num_items * 5;

    logic    clk;
    logic    rst_n;
    logic    in_valid;
    logic    in_ready;
    id_ex_t  in_bus;
    logic    out_valid;
    logic    out_ready;
    ex_mem_t out_bus;
    fwd_t    mem_fwd;
    fwd_t    wb_fwd;
    logic    branch_flush;
    logic    pc_update;
    xlen_t   dnpc;

    // scoreboard, holds what the stage register should hold
    id_ex_t      sb_q[$];
    logic        exp_valid = 1'b0;
    logic        exp_update = 1'b0;
    xlen_t       exp_result;
    xlen_t       exp_pc;
    xlen_t       exp_dnpc;
    reg_addr_t   exp_rd;
    logic [63:0] rng_state = 64'd1;
    int          err_count = 0;
    int          accepted = 0;
    int          handoffs = 0;
    int          cycles = 0;

    tb_clock_gen i_clock_gen (.clk(clk), .rst_n(rst_n));

    ex_stage i_dut (
        .clk(clk), .rst_n(rst_n),
        .in_valid(in_valid), .in_ready(in_ready), .in_bus(in_bus),
        .out_valid(out_valid), .out_ready(out_ready), .out_bus(out_bus),
        .mem_fwd(mem_fwd), .wb_fwd(wb_fwd), .branch_flush(branch_flush),
        .pc_update(pc_update), .dnpc(dnpc)
    );

    function automatic logic [63:0] xorshift64(input logic [63:0] x);
        logic [63:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 7);
        y = y ^ (y << 17);
        return y;
    endfunction

    function logic [63:0] rand_word();
        rng_state = xorshift64(rng_state);
        return rng_state;
    endfunction

    // registers limited to x0..x7 so forwarding hits often
    function id_ex_t random_item();
        id_ex_t      it;
        logic [63:0] r;
        logic [63:0] r2;
        r  = rand_word();
        r2 = rand_word();
        it.pc       = {32'd0, r[31:2], 2'b00};
        it.op_class = op_class_e'(r[34:32] % 3'd7);
        it.alu_op   = alu_op_e'(4'(r[39:35] % 5'd10));
        // decode sends add for everything outside the alu classes
        if (!(it.op_class inside {alu_reg, alu_imm})) it.alu_op = add;
        it.word_op = r[40] && it.op_class inside {alu_reg, alu_imm} &&
                     it.alu_op inside {add, sub, sll, srl, sra};
        case (r[43:41] % 3'd6)
            3'd0:    it.branch_cond = beq;
            3'd1:    it.branch_cond = bne;
            3'd2:    it.branch_cond = blt;
            3'd3:    it.branch_cond = bge;
            3'd4:    it.branch_cond = bltu;
            default: it.branch_cond = bgeu;
        endcase
        it.rd   = (it.op_class == branch) ? 5'd0 : {2'b00, r[46:44]};
        it.rs1  = {2'b00, r[49:47]};
        it.rs2  = {2'b00, r[52:50]};
        it.src1 = rand_word();
        // equal operands now and then for beq and bge
        it.src2 = r[53] ? it.src1 : rand_word();
        if (it.op_class inside {lui, auipc})
            it.imm = {{32{r2[19]}}, r2[19:0], 12'd0};
        else
            it.imm = {{52{r2[11]}}, r2[11:0]};
        return it;
    endfunction

    function fwd_t random_fwd();
        logic [63:0] r;
        fwd_t        f;
        r = rand_word();
        f.write = r[0] | r[1];
        f.rd    = {2'b00, r[4:2]};
        f.data  = rand_word();
        return f;
    endfunction

    // expected values for this cycle, then the effect of the coming edge
    always @(negedge clk) begin
        id_ex_t head;
        if (!rst_n) begin
            sb_q.delete();
            exp_valid  = 1'b0;
            exp_update = 1'b0;
        end else begin
            exp_valid  = sb_q.size() != 0;
            exp_update = 1'b0;
            if (exp_valid) begin
                head       = sb_q[0];
                exp_pc     = head.pc;
                exp_rd     = head.rd;
                exp_result = expected_result(head, mem_fwd, wb_fwd);
                exp_update = out_ready && needs_redirect(head, mem_fwd, wb_fwd);
                exp_dnpc   = actual_next_pc(head, mem_fwd, wb_fwd);
            end
            // handoff or flush empties the slot
            if (exp_valid && (out_ready || branch_flush)) begin
                void'(sb_q.pop_front());
                if (out_ready) handoffs++;
            end
            if (in_valid && out_ready && !branch_flush) sb_q.push_back(in_bus);
        end
    end

    a_valid: assert property (@(posedge clk) disable iff (!rst_n) out_valid == exp_valid)
        else begin
            err_count++;
            $display("error scoreboard_valid expected %0b actual %0b",
                     $sampled(exp_valid), $sampled(out_valid));
        end

    a_result: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && out_ready |-> out_bus.result == exp_result)
        else begin
            err_count++;
            $display("error alu_result expected %h actual %h",
                     $sampled(exp_result), $sampled(out_bus.result));
        end

    a_pc_rd: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && out_ready |-> out_bus.pc == exp_pc && out_bus.rd == exp_rd)
        else begin
            err_count++;
            $display("error pc_rd expected %h/%0d actual %h/%0d", $sampled(exp_pc),
                     $sampled(exp_rd), $sampled(out_bus.pc), $sampled(out_bus.rd));
        end

    a_redirect: assert property (@(posedge clk) disable iff (!rst_n) pc_update == exp_update)
        else begin
            err_count++;
            $display("error redirect expected %0b actual %0b",
                     $sampled(exp_update), $sampled(pc_update));
        end

    a_dnpc: assert property (@(posedge clk) disable iff (!rst_n) pc_update |-> dnpc == exp_dnpc)
        else begin
            err_count++;
            $display("error next_pc expected %h actual %h", $sampled(exp_dnpc), $sampled(dnpc));
        end

    // decode sees the same ready that MEM gives
    a_ready: assert property (@(posedge clk) disable iff (!rst_n) in_ready == out_ready)
        else begin
            err_count++;
            $display("error in_ready expected %0b actual %0b",
                     $sampled(out_ready), $sampled(in_ready));
        end

    // stall side effects
    a_stall_quiet: assert property (@(posedge clk) disable iff (!rst_n)
        !out_ready |-> !in_ready && !pc_update)
        else begin
            err_count++;
            $display("in_ready or pc_update went high while out_ready was low");
        end

    a_hold_stable: assert property (@(posedge clk) disable iff (!rst_n)
        $past(out_valid && !out_ready) && $stable(mem_fwd) && $stable(wb_fwd)
            |-> $stable(out_bus))
        else begin
            err_count++;
            $display("out_bus changed during a stall with quiet forwarding inputs");
        end

    a_flush: assert property (@(posedge clk) disable iff (!rst_n) branch_flush |=> !out_valid)
        else begin
            err_count++;
            $display("out_valid still high in the cycle after a flush");
        end

    a_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        in_valid && in_ready && !branch_flush |=> out_valid)
        else begin
            err_count++;
            $display("an accepted item was not on out_valid one cycle later");
        end

    a_reset_quiet: assert property (@(posedge clk)
        !rst_n || $past(!rst_n) |-> !out_valid && !pc_update)
        else begin
            err_count++;
            $display("out_valid or pc_update high during or right after reset");
        end

    // watchdog
    initial begin
        while (cycles < max_cycles) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout after %0d cycles, stimulus did not finish", cycles);
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        logic        consumed;
        logic        flushed;
        logic [63:0] r;
        in_valid     = 1'b0;
        in_bus       = '0;
        out_ready    = 1'b0;
        mem_fwd      = '0;
        wb_fwd       = '0;
        branch_flush = 1'b0;
        @(posedge rst_n);
        @(posedge clk);
        #1;
        in_bus    = random_item();
        in_valid  = 1'b1;
        out_ready = 1'b1;
        while (accepted < num_items) begin
            @(posedge clk);
            consumed = in_valid && out_ready;
            flushed  = branch_flush;
            if (consumed && !flushed) accepted++;
            #1;
            r = rand_word();
            // decode holds its item until taken
            if (consumed || !in_valid) begin
                in_bus   = random_item();
                in_valid = r[1:0] != 2'b00;
            end
            out_ready    = r[3:2] != 2'b00;
            branch_flush = r[9:4] == 6'd0;
            if (r[11:10] == 2'b00) begin
                mem_fwd = random_fwd();
                wb_fwd  = random_fwd();
            end
        end
        // drain the last item
        in_valid     = 1'b0;
        branch_flush = 1'b0;
        out_ready    = 1'b1;
        do begin
            @(posedge clk);
            #1;
        end while (out_valid);
        $display("items %0d handoffs %0d cycles %0d errors %0d",
                 accepted, handoffs, cycles, err_count);
        if (err_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
